/* logic/camera_capture_top.sv */
// ************************************************************************
// Capture front end for one parallel-bus sensor with plain ports
// ************************************************************************
`timescale 1ns/1ns

module camera_capture_top (
    input  logic clk,
    input  logic reset,
    input  logic camera_pixel_clock,
    input  logic camera_fv,
    input  logic camera_lv,
    input  camera_pkg::pixel_t camera_pixel_in,
    input  logic request_image,
    output logic camera_reset_bar,
    output logic sample_pixel,
    output logic keep_pixel,
    output logic image_started,
    output logic image_finished,
    output camera_pkg::byte_t data
);

    pixel_bus_if bus ();
    line_status_if status ();

    logic tracker_hold;
    logic streaming;
    camera_pkg::line_t target_line;
    logic all_done;

    // Decode
    input_conditioner u_conditioner (
        .clk(clk),
        .reset(reset),
        .pixel_clock(camera_pixel_clock),
        .fv(camera_fv),
        .lv(camera_lv),
        .pixel_in(camera_pixel_in),
        .bus(bus.source)
    );

    // Execute
    line_tracker u_tracker (
        .clk(clk),
        .reset(reset),
        .tracker_hold(tracker_hold),
        .bus(bus.sink),
        .status(status.source)
    );

    interleave_selector u_selector (
        .clk(clk),
        .reset(reset),
        .streaming(streaming),
        .status(status.sink),
        .target_line(target_line),
        .all_done(all_done)
    );

    // Result
    capture_controller u_controller (
        .clk(clk),
        .reset(reset),
        .request_image(request_image),
        .bus(bus.sink),
        .status(status.sink),
        .target_line(target_line),
        .all_done(all_done),
        .camera_reset_bar(camera_reset_bar),
        .tracker_hold(tracker_hold),
        .streaming(streaming),
        .keep_pixel(keep_pixel),
        .image_started(image_started),
        .image_finished(image_finished)
    );

    assign sample_pixel = bus.sample;
    // Only the upper bits of each pixel go to the FIFO
    assign data = bus.pixel[$bits(camera_pkg::pixel_t)-1 -: $bits(camera_pkg::byte_t)];

endmodule

/* logic/camera_pkg.sv */
// ************************************************************************
// Frame geometry, sampling timing and shared types for the capture path.
// Every stage refers to these by scoped name.
// ************************************************************************
package camera_pkg;

    // Depth of the flip-flop chain that brings the sensor pins into clk
    localparam int sync_stages = 10;
    // System cycles from the filtered pixel clock fall to the sample strobe
    localparam int sample_delay = 2;

    // Frame geometry of the sensor window
    localparam int line_pixels = 16;
    localparam int frame_lines = 16;

    // Interleaved frames per image; 2 * n_interleave must divide frame_lines
    localparam int n_interleave = 4;
    // Read two lines, then jump so the average step equals n_interleave
    localparam int interleave_jump = 2 * n_interleave - 1;
    localparam int lines_per_interleave = frame_lines / n_interleave;

    // Camera reset hold after system reset
    localparam int boot_cycles = 64;

    typedef logic [11:0] pixel_t;
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] line_t;
    typedef logic [4:0]  frame_idx_t;
    // Pixel clock, FV, LV and data moved as one bus through the conditioner
    typedef logic [$bits(pixel_t)+2:0] cond_t;

    typedef enum logic [2:0] {
        boot,
        wait_frame_start,
        wait_frame_end,
        idle,
        commanded_wait,
        streaming_image
    } capture_state_t;

endpackage

/* logic/capture_controller.sv */
// ************************************************************************
// Boots the sensor, lets one full frame pass, then serves image requests
// and decides which sampled pixels are kept
// ************************************************************************
`timescale 1ns/1ns

module capture_controller (
    input  logic clk,
    input  logic reset,
    input  logic request_image,
    pixel_bus_if.sink bus,
    line_status_if.sink status,
    input  camera_pkg::line_t target_line,
    input  logic all_done,
    output logic camera_reset_bar,
    output logic tracker_hold,
    output logic streaming,
    output logic keep_pixel,
    output logic image_started,
    output logic image_finished
);

    camera_pkg::capture_state_t state;
    camera_pkg::capture_state_t state_next;
    logic [$clog2(camera_pkg::boot_cycles+1)-1:0] boot_count;
    logic boot_over;

    assign boot_over = (boot_count >= camera_pkg::boot_cycles);

    // Boot timer runs only while the camera is held in reset
    always_ff @(posedge clk) begin
        if (reset || state != camera_pkg::boot) begin
            boot_count <= '0;
        end else if (!boot_over) begin
            boot_count <= boot_count + 1'b1;
        end
    end

    // ********************************************************************
    // Capture FSM
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= camera_pkg::boot;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            camera_pkg::boot: begin
                if (boot_over) state_next = camera_pkg::wait_frame_start;
            end
            // Let one whole frame go by so tracking starts between frames
            camera_pkg::wait_frame_start: begin
                if (bus.fv) state_next = camera_pkg::wait_frame_end;
            end
            camera_pkg::wait_frame_end: begin
                if (bus.out_of_frame) state_next = camera_pkg::idle;
            end
            camera_pkg::idle: begin
                if (request_image) state_next = camera_pkg::commanded_wait;
            end
            // Streaming must never begin in the middle of a frame
            camera_pkg::commanded_wait: begin
                if (bus.out_of_frame) state_next = camera_pkg::streaming_image;
            end
            camera_pkg::streaming_image: begin
                if (all_done) state_next = camera_pkg::idle;
            end
            default: begin
                state_next = camera_pkg::boot;
            end
        endcase
    end

    // Sensor is released as soon as boot ends
    assign camera_reset_bar = (state != camera_pkg::boot);

    // Tracking stays cleared until the first inter-frame gap after boot
    assign tracker_hold = (state == camera_pkg::boot)
                       || (state == camera_pkg::wait_frame_start)
                       || (state == camera_pkg::wait_frame_end);

    assign streaming = (state == camera_pkg::streaming_image);
    assign image_started = streaming;
    assign image_finished = !streaming;

    // FIFO write enable, read alongside the sample strobe
    assign keep_pixel = status.line_active
                     && (status.line_in_frame == target_line)
                     && streaming;

endmodule

/* logic/input_conditioner.sv */
// ************************************************************************
// Brings the sensor pins into the system clock domain, votes out
// single-cycle glitches and makes the pixel sample strobe
// ************************************************************************
`timescale 1ns/1ns

module input_conditioner (
    input  logic clk,
    input  logic reset,
    input  logic pixel_clock,
    input  logic fv,
    input  logic lv,
    input  camera_pkg::pixel_t pixel_in,
    pixel_bus_if.source bus
);

    // All pins travel together so their relative timing is kept
    camera_pkg::cond_t sync_chain [camera_pkg::sync_stages];
    camera_pkg::cond_t filt_buf [3];
    camera_pkg::cond_t vote;
    camera_pkg::cond_t filtered;

    logic pclk_filtered;
    logic pclk_vote;
    logic pclk_fell;
    logic [camera_pkg::sample_delay-1:0] sample_pipe;

    // ********************************************************************
    // Synchronizer chain and three-deep filter buffer
    // ********************************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < camera_pkg::sync_stages; i++) begin
                sync_chain[i] <= '0;
            end
            for (int i = 0; i < 3; i++) begin
                filt_buf[i] <= '0;
            end
            filtered <= '0;
        end else begin
            sync_chain[0] <= {pixel_clock, fv, lv, pixel_in};
            for (int i = 1; i < camera_pkg::sync_stages; i++) begin
                sync_chain[i] <= sync_chain[i-1];
            end
            filt_buf[0] <= sync_chain[camera_pkg::sync_stages-1];
            filt_buf[1] <= filt_buf[0];
            filt_buf[2] <= filt_buf[1];
            // One more stage so edges can be seen between vote and filtered
            filtered <= vote;
        end
    end

    // Two-of-three vote on every bit, so a one-cycle blip never gets through
    assign vote = (filt_buf[2] & filt_buf[1])
                | (filt_buf[2] & filt_buf[0])
                | (filt_buf[1] & filt_buf[0]);

    // ********************************************************************
    // Edge detection and sample strobe
    // ********************************************************************
    // The pixel clock sits in the top bit of the conditioned bus
    assign pclk_filtered = filtered[$bits(camera_pkg::cond_t)-1];
    assign pclk_vote = vote[$bits(camera_pkg::cond_t)-1];
    // High for one cycle as the filtered pixel clock goes low
    assign pclk_fell = pclk_filtered & ~pclk_vote;

    // Data moves on the pixel clock rise, so sampling a little after the
    // fall lands in the middle of the stable window
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_pipe <= '0;
        end else begin
            sample_pipe[0] <= pclk_fell;
            for (int i = 1; i < camera_pkg::sample_delay; i++) begin
                sample_pipe[i] <= sample_pipe[i-1];
            end
        end
    end

    assign bus.pixel = filtered[$bits(camera_pkg::pixel_t)-1:0];
    assign bus.fv = filtered[$bits(camera_pkg::pixel_t)+1];
    assign bus.lv = filtered[$bits(camera_pkg::pixel_t)];
    assign bus.sample = sample_pipe[camera_pkg::sample_delay-1];

    // Blank data with both valid flags low only happens between frames
    assign bus.out_of_frame = !bus.fv && !bus.lv && (bus.pixel == '0);

endmodule

/* logic/interleave_selector.sv */
// ************************************************************************
// Picks the sensor line to keep next, reading line pairs across several
// interleaved frames so the Bayer pattern is kept intact
// ************************************************************************
`timescale 1ns/1ns

module interleave_selector (
    input  logic clk,
    input  logic reset,
    input  logic streaming,
    line_status_if.sink status,
    output camera_pkg::line_t target_line,
    output logic all_done
);

    camera_pkg::line_t line_in_interleave;
    camera_pkg::frame_idx_t frame_idx;
    camera_pkg::frame_idx_t next_frame_idx;
    logic target_done;
    logic last_line;
    logic last_frame;

    // The line just finished was the one we were keeping
    assign target_done = status.line_advanced && (status.prev_line == target_line);

    assign last_line = line_in_interleave
                    >= camera_pkg::line_t'(camera_pkg::lines_per_interleave - 1);
    assign last_frame = frame_idx
                     >= camera_pkg::frame_idx_t'(camera_pkg::n_interleave - 1);
    assign next_frame_idx = frame_idx + camera_pkg::frame_idx_t'(1);

    // ********************************************************************
    // Target sequence
    // ********************************************************************
    // Frame k reads 2k, 2k+1, then 2k + 2n, 2k + 2n + 1 and so on, which
    // gives the order 0,1,8,9 then 2,3,10,11 for four interleaved frames
    always_ff @(posedge clk) begin
        if (reset || !streaming) begin
            target_line <= '0;
            line_in_interleave <= '0;
            frame_idx <= '0;
            all_done <= 1'b0;
        end else if (target_done && !all_done) begin
            if (last_line) begin
                line_in_interleave <= '0;
                if (last_frame) begin
                    all_done <= 1'b1;
                end else begin
                    frame_idx <= next_frame_idx;
                    // Each interleaved frame starts two lines further down
                    target_line <= camera_pkg::line_t'({next_frame_idx, 1'b0});
                end
            end else begin
                line_in_interleave <= line_in_interleave + camera_pkg::line_t'(1);
                if (!target_line[0]) begin
                    // Second line of the Bayer pair
                    target_line <= target_line + camera_pkg::line_t'(1);
                end else begin
                    // Jump over the pairs that belong to the other frames
                    target_line <= target_line
                                 + camera_pkg::line_t'(camera_pkg::interleave_jump);
                end
            end
        end
    end

endmodule

/* logic/line_tracker.sv */
// ************************************************************************
// Follows the position inside a sensor frame: line activity, pixel count
// and line number, all held cleared while tracker_hold is high
// ************************************************************************
`timescale 1ns/1ns

module line_tracker (
    input  logic clk,
    input  logic reset,
    input  logic tracker_hold,
    pixel_bus_if.sink bus,
    line_status_if.source status
);

    logic line_active;
    camera_pkg::line_t pixel_count;
    camera_pkg::line_t line_in_frame;
    camera_pkg::line_t prev_line;
    logic can_advance;
    logic line_advanced;
    logic line_full;
    logic blanking;
    logic advance_now;

    // ********************************************************************
    // Line state and pixel counter
    // ********************************************************************
    // A greater-or-equal test so a corrupted count still ends the line
    assign line_full = (pixel_count >= camera_pkg::line_pixels);

    always_ff @(posedge clk) begin
        if (reset || tracker_hold) begin
            line_active <= 1'b0;
            pixel_count <= '0;
        end else if (line_active) begin
            // Stay in the line until every pixel is counted and LV has
            // dropped, so the tail of a line cannot look like a new one
            if (line_full) begin
                if (!bus.lv) begin
                    line_active <= 1'b0;
                    pixel_count <= '0;
                end
            end else if (bus.sample) begin
                pixel_count <= pixel_count + camera_pkg::line_t'(1);
            end
        end else if (bus.lv) begin
            line_active <= 1'b1;
        end
    end

    // ********************************************************************
    // Line counter
    // ********************************************************************
    assign blanking = (bus.pixel == '0);

    // Counts move only in the blanking after a finished line, and the
    // flag limits this to one step per line
    assign advance_now = !bus.lv && !line_active && blanking && can_advance;

    always_ff @(posedge clk) begin
        if (reset || tracker_hold) begin
            line_in_frame <= '0;
            prev_line <= '0;
            can_advance <= 1'b0;
            line_advanced <= 1'b0;
        end else begin
            line_advanced <= 1'b0;
            if (line_active) begin
                can_advance <= 1'b1;
            end
            if (advance_now) begin
                can_advance <= 1'b0;
                prev_line <= line_in_frame;
                line_advanced <= 1'b1;
                // The last line of a frame may end right as FV drops
                if (bus.out_of_frame) begin
                    line_in_frame <= '0;
                end else begin
                    line_in_frame <= line_in_frame + camera_pkg::line_t'(1);
                end
            end else if (bus.out_of_frame && !line_active) begin
                // Between frames the count restarts at line zero
                line_in_frame <= '0;
            end
        end
    end

    assign status.line_active = line_active;
    assign status.line_in_frame = line_in_frame;
    assign status.prev_line = prev_line;
    assign status.line_advanced = line_advanced;

endmodule

/* logic/pixel_bus_if.sv */
// ************************************************************************
// Conditioned sensor bus from the decode stage, and the line position
// status that the line tracker hands to the later stages
// ************************************************************************
`timescale 1ns/1ns

interface pixel_bus_if;
    camera_pkg::pixel_t pixel;
    logic fv;
    logic lv;
    // One-cycle strobe when the pixel data is settled
    logic sample;
    // FV low, LV low and blank data all at once
    logic out_of_frame;

    modport source (output pixel, fv, lv, sample, out_of_frame);
    modport sink (input pixel, fv, lv, sample, out_of_frame);
endinterface

interface line_status_if;
    logic line_active;
    camera_pkg::line_t line_in_frame;
    camera_pkg::line_t prev_line;
    // Pulses once after a finished line has moved the line count
    logic line_advanced;

    modport source (output line_active, line_in_frame, prev_line, line_advanced);
    modport sink (input line_active, line_in_frame, prev_line, line_advanced);
endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the capture testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f vlog.f --top-module camera_capture_tb \
    -o camera_capture_sim > build.log 2>&1 \
    && ./obj_dir/camera_capture_sim > sim.log 2>&1 \
    || { echo "Build or run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* testbench/camera_capture_tb.sv */
// ************************************************************************
// Self-checking testbench for the capture front end. A sensor model plays
// the frames, and each line of the stim file requests and checks an image
// ************************************************************************
`timescale 1ns/1ns

module camera_capture_tb;

    // System cycles per sensor pixel clock, and blank pixel clocks per gap
    localparam int pclk_cycles = 8;
    localparam int blank_pclks = 4;
    localparam int max_tests = 32;

    logic clk;
    logic reset;
    logic camera_pixel_clock;
    logic camera_fv;
    logic camera_lv;
    camera_pkg::pixel_t camera_pixel_in;
    logic request_image;
    logic camera_reset_bar;
    logic sample_pixel;
    logic keep_pixel;
    logic image_started;
    logic image_finished;
    camera_pkg::byte_t data;

    // Test table from the stim file
    logic [8*24-1:0] test_name [max_tests];
    int test_offset [max_tests];
    int test_glitch [max_tests];
    int test_idle [max_tests];
    int test_expected [max_tests];
    int n_tests;

    // Parameters of the running test that the sensor picks up at frame start
    logic [8*24-1:0] cur_name;
    int cur_offset;
    int cur_glitch;
    int cur_idle;

    int frame_count;
    int errors;
    int kept;
    int total_kept;
    logic request_next;
    logic [31:0] lfsr_state;
    int limit_cycles;
    logic limit_ready;

    camera_capture_top DUT (
        .clk(clk),
        .reset(reset),
        .camera_pixel_clock(camera_pixel_clock),
        .camera_fv(camera_fv),
        .camera_lv(camera_lv),
        .camera_pixel_in(camera_pixel_in),
        .request_image(request_image),
        .camera_reset_bar(camera_reset_bar),
        .sample_pixel(sample_pixel),
        .keep_pixel(keep_pixel),
        .image_started(image_started),
        .image_finished(image_finished),
        .data(data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************
    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("FAIL %0s %0s expected %0d actual %0d", cur_name, what, expected, actual);
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Takes one LFSR step per bit and puts the first bit in the MSB
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Frame k of the image reads 2k and 2k+1, then the pair 2*n_interleave
    // lines further down, and so on
    function automatic int expected_line(input int idx);
        int f;
        int j;
        f = idx / camera_pkg::lines_per_interleave;
        j = idx % camera_pkg::lines_per_interleave;
        return 2 * f + (j / 2) * 2 * camera_pkg::n_interleave + (j % 2);
    endfunction

    function automatic int expected_data(input int idx);
        int ln;
        ln = expected_line(idx / camera_pkg::line_pixels);
        return (cur_offset + 16 * ln + idx % camera_pkg::line_pixels) & 255;
    endfunction

    // Sensor cycles of one full frame including the gap after it
    function automatic int frame_cycles(input int idle_lines);
        int pclks;
        pclks = camera_pkg::frame_lines * (blank_pclks + camera_pkg::line_pixels)
              + blank_pclks
              + idle_lines * (camera_pkg::line_pixels + blank_pclks) + blank_pclks;
        return pclks * pclk_cycles;
    endfunction

    task automatic read_stim();
        int fd;
        int r;
        string line;
        logic [8*24-1:0] nm;
        int o;
        int g;
        int idl;
        int e;
        n_tests = 0;
        fd = $fopen("testbench/camera_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file testbench/camera_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            // Skip comments and empty lines
            if (r > 0 && line.len() > 1 && line[0] != "#") begin
                r = $sscanf(line, "%s %d %d %d %d", nm, o, g, idl, e);
                if (r == 5 && n_tests < max_tests) begin
                    test_name[n_tests] = nm;
                    test_offset[n_tests] = o;
                    test_glitch[n_tests] = g;
                    test_idle[n_tests] = idl;
                    test_expected[n_tests] = e;
                    n_tests++;
                end else begin
                    errors++;
                    $display("Stimulus line could not be read: %0s", line);
                end
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            errors++;
            $display("The stimulus file holds no tests");
        end
    endtask

    // Drives the request after the rising edge and looks at outputs on the falling edge
    task automatic step_cycle();
        @(posedge clk);
        #5;
        request_image = request_next;
        @(negedge clk);
        if (sample_pixel && keep_pixel) begin
            check_value("image_started at kept sample", 1, int'(image_started));
            check_value("data", expected_data(kept), int'(data));
            kept++;
            total_kept++;
        end
    endtask

    // One pixel clock period where a glitch_cycle of -1 means a clean period
    task automatic pixel_period(input logic fv, input logic lv, input int value,
                                input int glitch_cycle, input logic glitch_lv);
        for (int c = 0; c < pclk_cycles; c++) begin
            @(posedge clk);
            #5;
            camera_fv = fv;
            camera_lv = lv ^ (c == glitch_cycle && glitch_lv);
            camera_pixel_clock = (c < pclk_cycles / 2) ^ (c == glitch_cycle && !glitch_lv);
            // Data changes with the pixel clock rise and holds for the period
            camera_pixel_in = {8'(value), 4'b0000};
        end
    endtask

    // ************************************************************************
    // Sensor model
    // ************************************************************************
    initial begin : sensor
        int frame_offset;
        int frame_glitch;
        int frame_idle;
        int glitch_pix;
        int glitch_cycle;
        int kind;
        int phase;
        int bit_val;
        camera_pixel_clock = 1'b0;
        camera_fv = 1'b0;
        camera_lv = 1'b0;
        camera_pixel_in = '0;
        lfsr_state = 32'hf72f_d633;
        frame_count = 0;
        // The sensor stays quiet while it is held in reset
        while (camera_reset_bar !== 1'b1) begin
            @(posedge clk);
            #5;
        end
        forever begin
            frame_offset = cur_offset;
            frame_glitch = cur_glitch;
            frame_idle = cur_idle;
            frame_count++;
            for (int ln = 0; ln < camera_pkg::frame_lines; ln++) begin
                repeat (blank_pclks) pixel_period(1'b1, 1'b0, 0, -1, 1'b0);
                glitch_pix = -1;
                glitch_cycle = -1;
                kind = 0;
                if (frame_glitch != 0) begin
                    // One glitch per line lands in the middle of a clock phase
                    take_bits(3, glitch_pix);
                    glitch_pix = glitch_pix + 4;
                    take_bits(1, kind);
                    take_bits(1, phase);
                    take_bits(1, bit_val);
                    glitch_cycle = phase * 4 + 1 + bit_val;
                end
                for (int px = 0; px < camera_pkg::line_pixels; px++) begin
                    pixel_period(1'b1, 1'b1, frame_offset + 16 * ln + px,
                                 (px == glitch_pix) ? glitch_cycle : -1, kind == 0);
                end
            end
            repeat (blank_pclks) pixel_period(1'b1, 1'b0, 0, -1, 1'b0);
            repeat (frame_idle * (camera_pkg::line_pixels + blank_pclks) + blank_pclks) begin
                pixel_period(1'b0, 1'b0, 0, -1, 1'b0);
            end
        end
    end

    // Watchdog sized from the frame time of every test
    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles, %0d errors so far",
                 limit_cycles, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        int start_frame;
        logic started;
        reset = 1'b1;
        request_image = 1'b0;
        request_next = 1'b0;
        errors = 0;
        kept = 0;
        total_kept = 0;
        limit_ready = 1'b0;
        cur_name = "reset";
        cur_offset = 0;
        cur_glitch = 0;
        cur_idle = 1;
        read_stim();
        limit_cycles = camera_pkg::boot_cycles + 20;
        for (int t = 0; t < n_tests; t++) begin
            limit_cycles += frame_cycles(test_idle[t]) * (camera_pkg::n_interleave + 3);
        end
        limit_ready = 1'b1;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        @(negedge clk);
        check_value("camera_reset_bar", 0, int'(camera_reset_bar));
        check_value("image_finished", 1, int'(image_finished));
        check_value("image_started", 0, int'(image_started));
        check_value("sample_pixel", 0, int'(sample_pixel));
        check_value("keep_pixel", 0, int'(keep_pixel));
        while (!camera_reset_bar) step_cycle();
        for (int t = 0; t < n_tests; t++) begin
            cur_name = test_name[t];
            cur_offset = test_offset[t];
            cur_glitch = test_glitch[t];
            cur_idle = test_idle[t];
            // Request once a frame with the new settings is on the pins
            start_frame = frame_count;
            while (frame_count == start_frame) step_cycle();
            request_next = 1'b1;
            kept = 0;
            started = 1'b0;
            while (!(started && image_finished)) begin
                step_cycle();
                if (image_started) started = 1'b1;
                // Keep the request high for the first lines of streaming
                if (kept >= 4 * camera_pkg::line_pixels) request_next = 1'b0;
            end
            check_value("kept pixels", test_expected[t], kept);
        end
        $display("Summary: %0d tests, %0d kept pixels, %0d errors", n_tests, total_kept, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* testbench/camera_stim.txt */
# Columns: test name, data offset, glitch flag (1 = LV and pixel clock glitches),
# idle lines between frames, expected kept pixels per image
# Offsets are decimal; the pixel byte is offset + 16 * line + pixel, modulo 256
plain          0    0  2  256
offset_small   5    0  2  256
offset_wrap    200  0  1  256
glitch_plain   0    1  2  256
glitch_offset  90   1  3  256
short_gap      17   0  0  256
long_gap       33   0  5  256
glitch_short   128  1  0  256
repeat_plain   0    0  2  256
glitch_long    251  1  4  256

/* vlog.f */
logic/camera_pkg.sv
logic/pixel_bus_if.sv
logic/input_conditioner.sv
logic/line_tracker.sv
logic/interleave_selector.sv
logic/capture_controller.sv
logic/camera_capture_top.sv
testbench/camera_capture_tb.sv
